// ==== build.f ====
+incdir+.
verilog/predictor_pkg.sv
verilog/CounterBus.sv
verilog/CounterTable.sv
verilog/CounterArbiter.sv
verilog/LocalPredictor.sv
verilog/GlobalPredictor.sv
verilog/PredictorControl.sv
verilog/BranchPredictor.sv
tests/BranchPredictor_properties.sv
tests/BranchPredictorTb.sv

// ==== predictor_settings.svh ====
`ifndef PREDICTOR_SETTINGS_SVH
`define PREDICTOR_SETTINGS_SVH

// Length of a local history and of the global history register
`define PRED_HISTORY_BITS 10

// Index width inside one half of the counter table
// The index comes from address bits 11 to 2
`define PRED_INDEX_BITS 10

// Pattern counters start weakly not taken
`define PRED_COUNTER_INIT 2'd1

// Chooser counters start weakly preferring local
`define PRED_CHOOSER_INIT 2'd1

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module BranchPredictorTb \
    && ./obj_dir/VBranchPredictorTb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log \
    && echo "Simulation succeeded" \
    || { echo "Simulation did not succeed"; exit 1; }

// ==== tests/BranchPredictorTb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "predictor_settings.svh"

module BranchPredictorTb;
    import predictor_pkg::*;

    localparam int Slots = 2 ** `PRED_INDEX_BITS;

    logic        CLK;
    logic        RESET;
    logic        cmdValid;
    logic        cmdReady;
    logic        cmdResolve;
    logic [31:0] cmdInstr;
    logic [31:0] cmdAddr;
    logic        cmdTaken;
    logic        respValid;
    logic        respTaken;

    string       names [$];     // Stimulus table with one row per command
    logic        resolves [$];
    logic [31:0] instrs [$];
    logic [31:0] addrs [$];
    logic        outcomes [$];
    logic        expects [$];   // Model response for the row

    logic [`PRED_HISTORY_BITS-1:0] localHist [Slots];
    logic [`PRED_HISTORY_BITS-1:0] globalHist;
    counter_t                      patterns [2 * Slots];   // Local half then global half
    counter_t                      choosers [Slots];

    string       kindNames [8] = '{"Beq", "Bne", "Blez", "Bgtz",
                                   "Bltz", "Bgez", "Bltzal", "Bgezal"};
    logic [31:0] lcgState;
    int          errors;
    int          checks;
    int          cycles;
    int          cycleLimit;

    BranchPredictor UUT (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmdValid   (cmdValid),
        .cmdReady   (cmdReady),
        .cmdResolve (cmdResolve),
        .cmdInstr   (cmdInstr),
        .cmdAddr    (cmdAddr),
        .cmdTaken   (cmdTaken),
        .respValid  (respValid),
        .respTaken  (respTaken)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("Timeout: the DUT stopped answering after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] branchWord(logic [5:0] opcode, logic [4:0] rt);
        return {opcode, 5'd4, rt, 16'h0020};
    endfunction

    // Eight branch forms with REGIMM ones last
    function automatic logic [31:0] kindWord(logic [2:0] kind);
        logic [31:0] word;
        case (kind)
            3'd0: word = branchWord(6'h04, 5'd0);
            3'd1: word = branchWord(6'h05, 5'd0);
            3'd2: word = branchWord(6'h06, 5'd0);
            3'd3: word = branchWord(6'h07, 5'd0);
            3'd4: word = branchWord(6'h01, 5'd0);
            3'd5: word = branchWord(6'h01, 5'd1);
            3'd6: word = branchWord(6'h01, 5'd16);
            default: word = branchWord(6'h01, 5'd17);
        endcase
        return word;
    endfunction

    function automatic logic isBranchWord(logic [31:0] instr);
        logic mainOp;
        logic regimmOp;
        mainOp   = instr[31:26] inside {6'h04, 6'h05, 6'h06, 6'h07};
        regimmOp = (instr[31:26] == 6'h01) && (instr[20:16] inside {5'd0, 5'd1, 5'd16, 5'd17});
        return mainOp || regimmOp;
    endfunction

    function automatic counter_t stepCounter(counter_t value, logic up);
        counter_t result;
        result = value;
        if (up && value < 2'd3) begin
            result = value + 2'd1;
        end else if (!up && value > 2'd0) begin
            result = value - 2'd1;
        end
        return result;
    endfunction

    task automatic initModel();
        for (int i = 0; i < Slots; i++) begin
            localHist[i] = '0;
            choosers[i]  = `PRED_CHOOSER_INIT;
        end
        for (int i = 0; i < 2 * Slots; i++) begin
            patterns[i] = `PRED_COUNTER_INIT;
        end
        globalHist = '0;
    endtask

    // Guess from the old state, then train both halves and the chooser
    task automatic modelCommand(input logic resolve, input logic [31:0] instr,
                                input logic [31:0] addr, input logic taken,
                                output logic predicted);
        logic [`PRED_INDEX_BITS-1:0] slot;
        int       localIdx;
        int       globalIdx;
        counter_t localVal;
        counter_t globalVal;
        logic     localRight;
        logic     globalRight;
        slot        = addr[`PRED_INDEX_BITS+1:2];
        localIdx    = int'(localHist[slot]);
        globalIdx   = Slots + int'(globalHist ^ slot);   // Gshare
        localVal    = patterns[localIdx];
        globalVal   = patterns[globalIdx];
        localRight  = (localVal[1] == taken);
        globalRight = (globalVal[1] == taken);
        predicted   = 1'b0;
        if (isBranchWord(instr)) begin
            predicted = (choosers[slot] >= 2'd2) ? globalVal[1] : localVal[1];
            if (resolve) begin
                patterns[localIdx]  = stepCounter(localVal, taken);
                patterns[globalIdx] = stepCounter(globalVal, taken);
                localHist[slot] = {localHist[slot][`PRED_HISTORY_BITS-2:0], taken};
                globalHist      = {globalHist[`PRED_HISTORY_BITS-2:0], taken};
                if (localRight != globalRight) begin
                    choosers[slot] = stepCounter(choosers[slot], globalRight);
                end
            end
        end
    endtask

    task automatic addEntry(input string name, input logic resolve, input logic [31:0] instr,
                            input logic [31:0] addr, input logic taken);
        logic predicted;
        modelCommand(resolve, instr, addr, taken, predicted);
        names.push_back(name);
        resolves.push_back(resolve);
        instrs.push_back(instr);
        addrs.push_back(addr);
        outcomes.push_back(taken);
        expects.push_back(predicted);
    endtask

    // Fixed taken outcomes pushed through the global history
    task automatic fillHistory();
        for (int k = 0; k < `PRED_HISTORY_BITS - 1; k++) begin
            addEntry("historyFill", 1'b1, kindWord(3'd2), 32'h0040_0700, 1'b1);
        end
    endtask

    task automatic buildTable();
        logic [31:0] rnd;
        logic [31:0] pc;
        logic [31:0] word;
        addEntry("resetBeq", 1'b0, kindWord(3'd0), 32'h0040_0100, 1'b0);
        addEntry("resetBne", 1'b0, kindWord(3'd1), 32'h0040_0204, 1'b0);
        addEntry("resetBlez", 1'b0, kindWord(3'd2), 32'h0040_0308, 1'b0);
        addEntry("resetBgtz", 1'b0, kindWord(3'd3), 32'h0040_040c, 1'b0);
        for (int k = 0; k < 12; k++) begin
            addEntry("trainTaken", 1'b1, kindWord(3'd0), 32'h0040_0500, 1'b1);   // History fills
        end
        addEntry("trainedTaken", 1'b0, kindWord(3'd0), 32'h0040_0500, 1'b0);
        // Every branch form must reach the trained counter here
        for (int k = 0; k < 8; k++) begin
            addEntry({"decode", kindNames[k]}, 1'b1, kindWord(k[2:0]), 32'h0040_0500, 1'b1);
            addEntry({"decode", kindNames[k]}, 1'b0, kindWord(k[2:0]), 32'h0040_0500, 1'b0);
        end
        // None of these may touch predictor state
        // One not-taken shift into the history would turn the last guess around
        addEntry("nonBranchAddi", 1'b1, {6'h08, 26'h0012345}, 32'h0040_0500, 1'b0);
        addEntry("nonBranchJump", 1'b1, {6'h02, 26'h0000040}, 32'h0040_0500, 1'b0);
        addEntry("regimmRt2", 1'b1, branchWord(6'h01, 5'd2), 32'h0040_0500, 1'b0);
        addEntry("regimmRt18", 1'b1, branchWord(6'h01, 5'd18), 32'h0040_0500, 1'b0);
        addEntry("nonBranchPredict", 1'b0, {6'h08, 26'h0012345}, 32'h0040_0500, 1'b0);
        addEntry("afterNonBranch", 1'b0, kindWord(3'd0), 32'h0040_0500, 1'b0);
        // Second branch goes the opposite way to the first
        // Nine fillers leave only the first outcome in the global history
        for (int k = 0; k < 24; k++) begin
            rnd = nextRandom();
            fillHistory();
            addEntry("correlateFirst", 1'b1, kindWord(3'd0), 32'h0040_0600, rnd[16]);
            addEntry("correlateSecond", 1'b1, kindWord(3'd1), 32'h0040_0684, ~rnd[16]);
        end
        fillHistory();
        addEntry("correlateFirst", 1'b1, kindWord(3'd0), 32'h0040_0600, 1'b0);
        addEntry("correlatePredict", 1'b0, kindWord(3'd1), 32'h0040_0684, 1'b0);
        for (int k = 0; k < 200; k++) begin
            rnd  = nextRandom();
            pc   = 32'h0040_1000 + 32'(rnd[10:8]) * 32'h24;     // Eight addresses
            word = (rnd[7:5] == 3'd0) ? {6'h08, 26'h0000777} : kindWord(rnd[14:12]);
            addEntry("random", rnd[25] || rnd[26], word, pc, rnd[22] || rnd[8]);
        end
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch in %s: expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    // Valid goes up at once, so it often waits on cmdReady
    task automatic applyEntry(input int i);
        int latency;
        int expectedLatency;
        cmdResolve = resolves[i];
        cmdInstr   = instrs[i];
        cmdAddr    = addrs[i];
        cmdTaken   = outcomes[i];
        cmdValid   = 1'b1;
        while (!cmdReady) begin
            @(posedge CLK);
            #1;
        end
        @(posedge CLK);     // Accepted here
        #1;
        cmdValid = 1'b0;
        checkValue({names[i], "Ready"}, 32'd0, 32'(cmdReady));
        latency = 1;
        while (!respValid) begin
            @(posedge CLK);
            #1;
            latency++;
        end
        // Both peers ask together and the table takes one per cycle
        expectedLatency = isBranchWord(instrs[i]) ? 4 : 1;
        checkValue(names[i], 32'(expects[i]), 32'(respTaken));
        checkValue({names[i], "Latency"}, 32'(expectedLatency), 32'(latency));
    endtask

    initial begin
        RESET      = 1'b0;
        cmdValid   = 1'b0;
        cmdResolve = 1'b0;
        cmdInstr   = '0;
        cmdAddr    = '0;
        cmdTaken   = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        cycleLimit = 0;
        lcgState   = 32'd81;
        initModel();
        buildTable();
        cycleLimit = names.size() * 6 + 50;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b1;
        checkValue("resetReady", 32'd1, 32'(cmdReady));
        checkValue("resetRespValid", 32'd0, 32'(respValid));
        for (int i = 0; i < names.size(); i++) begin
            applyEntry(i);
        end
        @(posedge CLK);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/BranchPredictor_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module BranchPredictorProperties (
    input wire logic CLK,
    input wire logic RESET,
    input wire logic cmdValid,
    input wire logic cmdReady,
    input wire logic respValid,
    input wire logic localGnt,
    input wire logic globalGnt,
    input wire logic localDone,
    input wire logic globalDone
);

    logic inFlight;     // From acceptance through the response cycle

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            inFlight <= 1'b0;
        end else if (cmdValid && cmdReady) begin
            inFlight <= 1'b1;
        end else if (respValid) begin
            inFlight <= 1'b0;
        end
    end

    singleResponse: assert property (@(posedge CLK) disable iff (!RESET)
        respValid |=> !respValid) else $error("respValid lasted two cycles");

    busyWhileInFlight: assert property (@(posedge CLK) disable iff (!RESET)
        inFlight |-> !cmdReady) else $error("cmdReady high with a command in flight");

    oneGrant: assert property (@(posedge CLK) disable iff (!RESET)
        !(localGnt && globalGnt)) else $error("Both peers granted in one cycle");

    localAnswered: assert property (@(posedge CLK) disable iff (!RESET)
        localGnt |=> localDone) else $error("Local grant not followed by done");

    globalAnswered: assert property (@(posedge CLK) disable iff (!RESET)
        globalGnt |=> globalDone) else $error("Global grant not followed by done");

endmodule

bind BranchPredictor BranchPredictorProperties handshakeChecks (
    .CLK        (CLK),
    .RESET      (RESET),
    .cmdValid   (cmdValid),
    .cmdReady   (cmdReady),
    .respValid  (respValid),
    .localGnt   (localBus.gnt),
    .globalGnt  (globalBus.gnt),
    .localDone  (localDone),
    .globalDone (globalDone)
);

`default_nettype wire

// ==== verilog/BranchPredictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module BranchPredictor (
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        cmdValid,
    output logic             cmdReady,
    input  wire logic        cmdResolve,
    input  wire logic [31:0] cmdInstr,
    input  wire logic [31:0] cmdAddr,
    input  wire logic        cmdTaken,
    output logic             respValid,
    output logic             respTaken
);
    import predictor_pkg::*;

    logic        start;
    logic        resolve;
    logic [31:0] addr;
    logic        taken;
    logic        localDone;
    logic        globalDone;
    counter_t    localCounter;
    counter_t    globalCounter;
    logic        tblEn;
    tableOp_t    tblOp;
    tableAddr_t  tblAddr;
    counter_t    tblData;

    CounterBus localBus ();
    CounterBus globalBus ();

    PredictorControl predictorControl (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmdValid      (cmdValid),
        .cmdReady      (cmdReady),
        .cmdResolve    (cmdResolve),
        .cmdInstr      (cmdInstr),
        .cmdAddr       (cmdAddr),
        .cmdTaken      (cmdTaken),
        .respValid     (respValid),
        .respTaken     (respTaken),
        .start         (start),
        .resolve       (resolve),
        .addr          (addr),
        .taken         (taken),
        .localDone     (localDone),
        .localCounter  (localCounter),
        .globalDone    (globalDone),
        .globalCounter (globalCounter)
    );

    LocalPredictor localPredictor (
        .CLK     (CLK),
        .RESET   (RESET),
        .start   (start),
        .resolve (resolve),
        .addr    (addr),
        .taken   (taken),
        .done    (localDone),
        .counter (localCounter),
        .bus     (localBus.requester)
    );

    GlobalPredictor globalPredictor (
        .CLK     (CLK),
        .RESET   (RESET),
        .start   (start),
        .resolve (resolve),
        .addr    (addr),
        .taken   (taken),
        .done    (globalDone),
        .counter (globalCounter),
        .bus     (globalBus.requester)
    );

    CounterArbiter counterArbiter (
        .CLK       (CLK),
        .RESET     (RESET),
        .localBus  (localBus.arbiter),
        .globalBus (globalBus.arbiter),
        .tblEn     (tblEn),
        .tblOp     (tblOp),
        .tblAddr   (tblAddr),
        .tblData   (tblData)
    );

    CounterTable counterTable (
        .CLK     (CLK),
        .RESET   (RESET),
        .tblEn   (tblEn),
        .tblOp   (tblOp),
        .tblAddr (tblAddr),
        .tblData (tblData)
    );

endmodule

`default_nettype wire

// ==== verilog/CounterArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module CounterArbiter (
    input  wire logic                    CLK,
    input  wire logic                    RESET,
    CounterBus.arbiter                   localBus,
    CounterBus.arbiter                   globalBus,
    output logic                         tblEn,
    output predictor_pkg::tableOp_t      tblOp,
    output predictor_pkg::tableAddr_t    tblAddr,
    input  wire predictor_pkg::counter_t tblData
);
    import predictor_pkg::*;

    logic lastGlobal;   // Last grant went to global

    // On a tie the peer not served last wins
    always_comb begin
        localBus.gnt  = localBus.req && (!globalBus.req || lastGlobal);
        globalBus.gnt = globalBus.req && (!localBus.req || !lastGlobal);
    end

    assign tblEn = localBus.gnt || globalBus.gnt;

    // Half select comes from which port was granted
    always_comb begin
        if (globalBus.gnt) begin
            tblOp   = globalBus.op;
            tblAddr = {1'b1, globalBus.index};
        end else begin
            tblOp   = localBus.op;
            tblAddr = {1'b0, localBus.index};
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            lastGlobal <= 1'b1;     // Local goes first
        end else if (tblEn) begin
            lastGlobal <= globalBus.gnt;
        end
    end

    // The flag still names last cycle's owner when the data returns
    assign localBus.rdata  = lastGlobal ? counter_t'(0) : tblData;
    assign globalBus.rdata = lastGlobal ? tblData : counter_t'(0);

endmodule

`default_nettype wire

// ==== verilog/CounterBus.sv ====
`timescale 1ns/10ps
`default_nettype none

// One predictor's path to the shared counter table
interface CounterBus;
    import predictor_pkg::*;

    logic        req;       // Held until gnt
    tableOp_t    op;
    tableIndex_t index;     // Index within this peer's half
    logic        gnt;       // Same cycle as req when granted
    counter_t    rdata;     // Valid the cycle after gnt

    modport requester (
        output req,
        output op,
        output index,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  op,
        input  index,
        output gnt,
        output rdata
    );

endinterface

`default_nettype wire

// ==== verilog/CounterTable.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "predictor_settings.svh"

module CounterTable (
    input  wire logic                      CLK,
    input  wire logic                      RESET,
    input  wire logic                      tblEn,
    input  wire predictor_pkg::tableOp_t   tblOp,
    input  wire predictor_pkg::tableAddr_t tblAddr,
    output predictor_pkg::counter_t        tblData
);
    import predictor_pkg::*;

    localparam int Depth = 2 ** (`PRED_INDEX_BITS + 1);   // Local half then global half

    counter_t cells [Depth];

    // Count ops write back the saturated value
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < Depth; i++) begin
                cells[i] <= `PRED_COUNTER_INIT;
            end
        end else if (tblEn && tblOp != opRead) begin
            cells[tblAddr] <= countStep(cells[tblAddr], tblOp == opCountTaken);
        end
    end

    // Old value goes out, also for count ops
    always_ff @(posedge CLK) begin
        if (tblEn) begin
            tblData <= cells[tblAddr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/GlobalPredictor.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "predictor_settings.svh"

module GlobalPredictor (
    input  wire logic               CLK,
    input  wire logic               RESET,
    input  wire logic               start,
    input  wire logic               resolve,
    input  wire logic [31:0]        addr,
    input  wire logic               taken,
    output logic                    done,
    output predictor_pkg::counter_t counter,
    CounterBus.requester            bus
);
    import predictor_pkg::*;

    history_t globalHistory;    // Outcomes of all resolved branches
    logic     pending;
    logic     granted;

    assign granted = bus.req && bus.gnt;

    // Gshare index
    assign bus.req   = start || pending;
    assign bus.op    = tableOpFor(resolve, taken);
    assign bus.index = globalHistory ^ addr[`PRED_INDEX_BITS+1:2];

    assign counter = bus.rdata;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pending       <= 1'b0;
            done          <= 1'b0;
            globalHistory <= '0;
        end else begin
            pending <= bus.req && !bus.gnt;
            done    <= granted;
            if (granted && resolve) begin
                globalHistory <= shiftHistory(globalHistory, taken);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/LocalPredictor.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "predictor_settings.svh"

module LocalPredictor (
    input  wire logic               CLK,
    input  wire logic               RESET,
    input  wire logic               start,
    input  wire logic               resolve,
    input  wire logic [31:0]        addr,
    input  wire logic               taken,
    output logic                    done,
    output predictor_pkg::counter_t counter,
    CounterBus.requester            bus
);
    import predictor_pkg::*;

    localparam int Entries = 2 ** `PRED_INDEX_BITS;

    history_t    histories [Entries];   // One history per branch slot
    tableIndex_t slot;
    logic        pending;               // Request waiting for grant
    logic        granted;

    assign slot    = addr[`PRED_INDEX_BITS+1:2];
    assign granted = bus.req && bus.gnt;

    // History of this branch is the counter index
    assign bus.req   = start || pending;
    assign bus.op    = tableOpFor(resolve, taken);
    assign bus.index = histories[slot];

    assign counter = bus.rdata;     // Valid together with done

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pending <= 1'b0;
            done    <= 1'b0;
            for (int i = 0; i < Entries; i++) begin
                histories[i] <= '0;
            end
        end else begin
            pending <= bus.req && !bus.gnt;
            done    <= granted;
            // Index was used this cycle, so the shift is safe now
            if (granted && resolve) begin
                histories[slot] <= shiftHistory(histories[slot], taken);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/PredictorControl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "predictor_settings.svh"

module PredictorControl (
    input  wire logic                    CLK,
    input  wire logic                    RESET,
    input  wire logic                    cmdValid,
    output logic                         cmdReady,
    input  wire logic                    cmdResolve,
    input  wire logic [31:0]             cmdInstr,
    input  wire logic [31:0]             cmdAddr,
    input  wire logic                    cmdTaken,
    output logic                         respValid,
    output logic                         respTaken,
    output logic                         start,
    output logic                         resolve,
    output logic [31:0]                  addr,
    output logic                         taken,
    input  wire logic                    localDone,
    input  wire predictor_pkg::counter_t localCounter,
    input  wire logic                    globalDone,
    input  wire predictor_pkg::counter_t globalCounter
);
    import predictor_pkg::*;

    localparam int Entries = 2 ** `PRED_INDEX_BITS;

    typedef enum logic [1:0] {
        sIdle,
        sWait,
        sRespond
    } state_t;

    state_t      state;
    counter_t    choosers [Entries];
    counter_t    chooser;
    counter_t    localHeld;
    counter_t    globalHeld;
    counter_t    localValue;
    counter_t    globalValue;
    tableIndex_t slot;
    logic        gotLocal;
    logic        gotGlobal;
    logic        accept;
    logic        isBranch;
    logic        allDone;
    logic        finish;
    logic        localRight;
    logic        globalRight;

    // Conditional branches only, jumps are not predicted here
    function automatic logic decodeBranch(logic [31:0] instr);
        logic result;
        result = 1'b0;
        case (instr[31:26])
            6'b000100, 6'b000101, 6'b000110, 6'b000111: begin
                result = 1'b1;      // BEQ BNE BLEZ BGTZ
            end
            6'b000001: begin
                case (instr[20:16])
                    5'd0, 5'd1, 5'd16, 5'd17: result = 1'b1;
                    default: result = 1'b0;
                endcase
            end
            default: result = 1'b0;
        endcase
        return result;
    endfunction

    assign cmdReady  = (state == sIdle);
    assign accept    = cmdValid && cmdReady;
    assign isBranch  = decodeBranch(cmdInstr);
    assign respValid = (state == sRespond);

    // The later done pulse still carries its counter live
    assign localValue  = localDone ? localCounter : localHeld;
    assign globalValue = globalDone ? globalCounter : globalHeld;
    assign allDone     = (gotLocal || localDone) && (gotGlobal || globalDone);
    assign finish      = (state == sWait) && allDone;

    assign slot        = addr[`PRED_INDEX_BITS+1:2];
    assign chooser     = choosers[slot];
    assign localRight  = (localValue[1] == taken);
    assign globalRight = (globalValue[1] == taken);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state     <= sIdle;
            start     <= 1'b0;
            gotLocal  <= 1'b0;
            gotGlobal <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                sIdle: begin
                    if (accept) begin
                        gotLocal  <= 1'b0;
                        gotGlobal <= 1'b0;
                        if (isBranch) begin
                            start <= 1'b1;      // Both peers start together
                            state <= sWait;
                        end else begin
                            state <= sRespond;
                        end
                    end
                end
                sWait: begin
                    if (localDone) begin
                        gotLocal <= 1'b1;
                    end
                    if (globalDone) begin
                        gotGlobal <= 1'b1;
                    end
                    if (allDone) begin
                        state <= sRespond;
                    end
                end
                default: state <= sIdle;    // Respond lasts one cycle
            endcase
        end
    end

    // Command fields and collected counters
    always_ff @(posedge CLK) begin
        if (accept) begin
            resolve   <= cmdResolve;
            addr      <= cmdAddr;
            taken     <= cmdTaken;
            respTaken <= 1'b0;      // Stays 0 for non-branches
        end
        if (localDone) begin
            localHeld <= localCounter;
        end
        if (globalDone) begin
            globalHeld <= globalCounter;
        end
        if (finish) begin
            respTaken <= chooser[1] ? globalValue[1] : localValue[1];
        end
    end

    // Chooser only moves when the peers disagree on correctness
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < Entries; i++) begin
                choosers[i] <= `PRED_CHOOSER_INIT;
            end
        end else if (finish && resolve && localRight != globalRight) begin
            choosers[slot] <= countStep(chooser, globalRight);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/predictor_pkg.sv ====
`default_nettype none
`include "predictor_settings.svh"

package predictor_pkg;

    typedef logic [1:0] counter_t;                          // High bit is the guess
    typedef logic [`PRED_INDEX_BITS-1:0] tableIndex_t;      // Index in one half
    typedef logic [`PRED_INDEX_BITS:0] tableAddr_t;         // Top bit selects the half
    typedef logic [`PRED_HISTORY_BITS-1:0] history_t;

    typedef enum logic [1:0] {
        opRead,
        opCountTaken,
        opCountNotTaken
    } tableOp_t;

    // Saturating step of a 2-bit counter
    function automatic counter_t countStep(counter_t value, logic up);
        counter_t next;
        next = value;
        if (up && value != 2'b11) begin
            next = value + 2'd1;
        end else if (!up && value != 2'b00) begin
            next = value - 2'd1;
        end
        return next;
    endfunction

    // Predict reads, resolve trains toward the outcome
    function automatic tableOp_t tableOpFor(logic resolve, logic taken);
        tableOp_t op;
        if (!resolve) begin
            op = opRead;
        end else if (taken) begin
            op = opCountTaken;
        end else begin
            op = opCountNotTaken;
        end
        return op;
    endfunction

    function automatic history_t shiftHistory(history_t history, logic taken);
        return {history[`PRED_HISTORY_BITS-2:0], taken};   // Newest outcome in bit 0
    endfunction

endpackage

`default_nettype wire
